// File: logic/mem_bus_pkg.sv
package mem_bus_pkg;

   //////////////////////////////////////////////////
   // wishbone side widths
   //////////////////////////////////////////////////

   // byte address, reduced from the 29 bit sdram space to 1024 words
   localparam int ADDR_W = 12;

   // address step from one 32 bit word to the next
   localparam int WORD_BYTES = 4;

   typedef logic [ADDR_W-1:0] wb_addr_t;   // byte address
   typedef logic [31:0]       wb_data_t;   // data word
   typedef logic [3:0]        wb_sel_t;    // byte selects, bit 0 is the low byte

   //////////////////////////////////////////////////
   // bus request from the master
   //////////////////////////////////////////////////

   typedef struct packed {
      logic     cyc;    // bus cycle in progress
      logic     stb;    // strobe, one per word
      logic     we;     // write enable
      wb_sel_t  sel;    // byte selects
      wb_addr_t addr;   // byte address, word aligned
      wb_data_t dat;    // write data
   } wb_req_t;

endpackage

// File: logic/mem_port_pkg.sv
package mem_port_pkg;

   //////////////////////////////////////////////////
   // memory port command encoding
   //////////////////////////////////////////////////

   // same codes as the sdram controller port
   typedef enum logic [2:0] {
      CMD_WRITE = 3'b010,   // write with autoprecharge
      CMD_READ  = 3'b011    // read with autoprecharge
   } cmd_instr_e;

   typedef logic [5:0] blen_t;   // burst length minus one

   localparam int READ_BURST_LEN = 8;    // words per read burst
   localparam int CMD_DEPTH      = 4;    // command queue entries
   localparam int WR_DEPTH       = 64;   // longest write block
   localparam int RD_DEPTH       = 16;   // read buffer words

   typedef struct packed {
      cmd_instr_e           instr;
      blen_t                blen;
      mem_bus_pkg::wb_addr_t addr;   // byte address of the first word
   } port_cmd_t;

   // one entry of the write queue, mask bit set means byte kept
   typedef struct packed {
      mem_bus_pkg::wb_data_t dat;
      mem_bus_pkg::wb_sel_t  mask;
   } wr_word_t;

   // wishbone to port controller states
   typedef enum logic [2:0] {
      ST_RST, ST_IDLE, ST_WR_FIFO, ST_WR_CMD, ST_RD_FIFO, ST_RD_CMD
   } ctrl_state_e;

endpackage

// File: logic/port_fifo.sv
`timescale 1ns/1ps

module port_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 16
) (
   input  logic             wb_clk,
   input  logic             mem_rst,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_dat_i,
   input  logic             pop_i,
   input  logic             flush_i,     // drop all contents in one cycle
   output logic [WIDTH-1:0] pop_dat_o,   // head word, valid while not empty
   output logic             full_o,
   output logic             empty_o
);

   typedef logic [$clog2(DEPTH)-1:0] ptr_t;
   typedef logic [$clog2(DEPTH):0]   cnt_t;

   logic [WIDTH-1:0] mem [DEPTH];   // storage, no reset
   ptr_t             wr_ptr;
   ptr_t             rd_ptr;
   cnt_t             cnt;           // words held
   logic             do_push;
   logic             do_pop;

   assign full_o    = (cnt == cnt_t'(DEPTH));
   assign empty_o   = (cnt == '0);
   assign do_push   = push_i & ~full_o;    // push into a full fifo is dropped
   assign do_pop    = pop_i & ~empty_o;
   assign pop_dat_o = mem[rd_ptr];         // show-ahead head

   always_ff @(posedge wb_clk) begin
      if (mem_rst || flush_i) begin   // flush wins over a push in the same cycle
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == ptr_t'(DEPTH-1)) ? '0 : wr_ptr + ptr_t'(1);
         if (do_pop)
            rd_ptr <= (rd_ptr == ptr_t'(DEPTH-1)) ? '0 : rd_ptr + ptr_t'(1);
         cnt <= cnt + cnt_t'(do_push) - cnt_t'(do_pop);   // both at once keeps the count
      end
   end

   always_ff @(posedge wb_clk) begin
      if (do_push && !flush_i)
         mem[wr_ptr] <= push_dat_i;
   end

endmodule

// File: logic/wb_burst_ctrl.sv
`timescale 1ns/1ps

module wb_burst_ctrl (
   input  logic                   wb_clk,
   input  logic                   mem_rst,
   input  mem_bus_pkg::wb_req_t   req_i,
   input  logic                   wr_full_i,
   input  logic                   cmd_full_i,
   input  logic                   rd_empty_i,
   input  mem_bus_pkg::wb_data_t  rd_dat_i,
   output logic                   wr_push_o,
   output mem_port_pkg::wr_word_t wr_word_o,
   output logic                   cmd_push_o,
   output mem_port_pkg::port_cmd_t cmd_o,
   output logic                   rd_pop_o,
   output logic                   rd_flush_o,
   output logic                   ack_o,
   output logic                   stall_o,
   output mem_bus_pkg::wb_data_t  dat_o
);

   mem_port_pkg::ctrl_state_e state;
   logic [6:0]            stb_cnt;    // accepted strobes in this cycle
   logic [6:0]            ack_cnt;    // read acks given in this cycle
   mem_bus_pkg::wb_addr_t adr_beg;    // first address of the write block
   mem_bus_pkg::wb_addr_t adr_next;   // address of the read fifo head
   logic                  rd_wait;    // read burst issued, no word seen yet
   logic [3:0]            rd_pend;    // cycles until the current burst is all in
   logic                  rd_busy;
   logic                  accept;
   logic                  pending;
   logic                  hit;
   logic                  serve;

   //////////////////////////////////////////////////
   // combinational bus side
   //////////////////////////////////////////////////

   assign stall_o = wr_full_i | cmd_full_i;                // the only back-pressure
   assign accept  = req_i.cyc & req_i.stb & ~stall_o;
   assign pending = (ack_cnt < stb_cnt) | accept;          // a read still owes an ack
   assign hit     = (req_i.addr == adr_next) & ~rd_empty_i;
   assign rd_busy = rd_wait | (rd_pend != '0);

   // write data goes straight into the queue, sel inverted into a mask
   assign wr_push_o      = accept & req_i.we;
   assign wr_word_o.dat  = req_i.dat;
   assign wr_word_o.mask = ~req_i.sel;

   // hand the fifo head to the bus and pop it in the same cycle
   // words still held during the flush cycle are stale
   assign serve = (state == mem_port_pkg::ST_IDLE && accept && !req_i.we && hit) ||
                  (state == mem_port_pkg::ST_RD_FIFO && req_i.cyc && pending && !rd_empty_i &&
                   !rd_flush_o);
   assign rd_pop_o = serve;

   always_ff @(posedge wb_clk) begin
      if (serve)
         dat_o <= rd_dat_i;
   end

   //////////////////////////////////////////////////
   // control fsm
   //////////////////////////////////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         state      <= mem_port_pkg::ST_RST;
         ack_o      <= 1'b0;
         cmd_push_o <= 1'b0;
         rd_flush_o <= 1'b0;
         stb_cnt    <= '0;
         ack_cnt    <= '0;
         adr_next   <= '1;   // unaligned, never matches a request
         rd_wait    <= 1'b0;
         rd_pend    <= '0;
      end else begin
         ack_o      <= wr_push_o | serve;   // one ack per write, one per served read
         cmd_push_o <= 1'b0;
         rd_flush_o <= 1'b0;
         if (accept)
            stb_cnt <= stb_cnt + 7'd1;
         if (serve) begin
            ack_cnt  <= ack_cnt + 7'd1;
            adr_next <= adr_next + mem_bus_pkg::wb_addr_t'(mem_bus_pkg::WORD_BYTES);
         end
         // after the first word shows up the engine streams the rest back to back
         // a word seen during the flush cycle belongs to the old burst
         if (rd_wait && !rd_empty_i && !rd_flush_o) begin
            rd_wait <= 1'b0;
            rd_pend <= 4'(mem_port_pkg::READ_BURST_LEN - 1);
         end else if (rd_pend != '0) begin
            rd_pend <= rd_pend - 4'd1;
         end
         case (state)
            mem_port_pkg::ST_RST: begin
               if (!req_i.cyc)   // let a cycle cut by reset finish
                  state <= mem_port_pkg::ST_IDLE;
            end
            mem_port_pkg::ST_IDLE: begin
               stb_cnt <= accept ? 7'd1 : 7'd0;
               ack_cnt <= serve ? 7'd1 : 7'd0;
               if (accept) begin
                  adr_beg <= req_i.addr;
                  if (req_i.we) begin
                     state <= mem_port_pkg::ST_WR_FIFO;
                  end else if (hit) begin
                     state <= mem_port_pkg::ST_RD_FIFO;   // served from the buffer
                  end else begin
                     // miss: drop the buffer and fetch a burst here
                     cmd_o.instr <= mem_port_pkg::CMD_READ;
                     cmd_o.blen  <= mem_port_pkg::blen_t'(mem_port_pkg::READ_BURST_LEN - 1);
                     cmd_o.addr  <= req_i.addr;
                     adr_next    <= req_i.addr;
                     if (cmd_full_i || rd_busy) begin
                        state <= mem_port_pkg::ST_RD_CMD;   // old burst still arriving
                     end else begin
                        cmd_push_o <= 1'b1;
                        rd_flush_o <= 1'b1;
                        rd_wait    <= 1'b1;
                        state      <= mem_port_pkg::ST_RD_FIFO;
                     end
                  end
               end
            end
            mem_port_pkg::ST_WR_FIFO: begin
               if (wr_full_i || !req_i.cyc) begin   // block ends here
                  cmd_o.instr <= mem_port_pkg::CMD_WRITE;
                  cmd_o.blen  <= mem_port_pkg::blen_t'(stb_cnt - 7'd1);
                  cmd_o.addr  <= adr_beg;
                  adr_next    <= '1;   // buffered read data is stale now
                  if (cmd_full_i) begin
                     state <= mem_port_pkg::ST_WR_CMD;
                  end else begin
                     cmd_push_o <= 1'b1;
                     rd_flush_o <= 1'b1;
                     state      <= mem_port_pkg::ST_IDLE;
                  end
               end
            end
            mem_port_pkg::ST_WR_CMD: begin
               if (!cmd_full_i) begin
                  cmd_push_o <= 1'b1;
                  rd_flush_o <= 1'b1;
                  state      <= mem_port_pkg::ST_IDLE;
               end
            end
            mem_port_pkg::ST_RD_FIFO: begin
               if (req_i.cyc && pending) begin
                  // buffer ran dry mid cycle, fetch the next burst
                  if (rd_empty_i && (|ack_cnt) && !rd_busy) begin
                     cmd_o.instr <= mem_port_pkg::CMD_READ;
                     cmd_o.blen  <= mem_port_pkg::blen_t'(mem_port_pkg::READ_BURST_LEN - 1);
                     cmd_o.addr  <= adr_next;
                     if (cmd_full_i) begin
                        state <= mem_port_pkg::ST_RD_CMD;
                     end else begin
                        cmd_push_o <= 1'b1;
                        rd_flush_o <= 1'b1;   // fifo is already empty here
                        rd_wait    <= 1'b1;
                     end
                  end
               end else begin
                  state <= mem_port_pkg::ST_IDLE;
               end
            end
            mem_port_pkg::ST_RD_CMD: begin
               if (!cmd_full_i && !rd_busy) begin   // command prepared earlier
                  cmd_push_o <= 1'b1;
                  rd_flush_o <= 1'b1;
                  rd_wait    <= 1'b1;
                  state      <= mem_port_pkg::ST_RD_FIFO;
               end
            end
            default: state <= mem_port_pkg::ST_RST;
         endcase
      end
   end

endmodule

// File: logic/burst_engine.sv
`timescale 1ns/1ps

module burst_engine (
   input  logic                    wb_clk,
   input  logic                    mem_rst,
   input  logic                    cmd_empty_i,
   input  mem_port_pkg::port_cmd_t cmd_i,
   output logic                    cmd_pop_o,
   input  logic                    wr_empty_i,
   input  mem_port_pkg::wr_word_t  wr_word_i,
   output logic                    wr_pop_o,
   input  logic                    rd_full_i,
   output logic                    rd_push_o,
   output mem_bus_pkg::wb_data_t   rd_dat_o
);

   typedef enum logic [1:0] {E_IDLE, E_WR, E_RD} eng_state_e;

   mem_bus_pkg::wb_data_t mem [1 << (mem_bus_pkg::ADDR_W - 2)];   // word array
   eng_state_e              st;
   mem_port_pkg::port_cmd_t cur;    // command in progress
   mem_port_pkg::blen_t     cnt;    // words done in this burst
   logic [mem_bus_pkg::ADDR_W-3:0] word_idx;
   logic                    last;

   // word index wraps at the array end
   assign word_idx = cur.addr[mem_bus_pkg::ADDR_W-1:2] + (mem_bus_pkg::ADDR_W-2)'(cnt);
   assign last     = (cnt == cur.blen);

   assign cmd_pop_o = (st == E_IDLE) & ~cmd_empty_i;
   assign wr_pop_o  = (st == E_WR) & ~wr_empty_i;   // one word per cycle
   assign rd_push_o = (st == E_RD) & ~rd_full_i;    // hold while the read fifo is full
   assign rd_dat_o  = mem[word_idx];

   //////////////////////////////////////////////////
   // burst sequencer
   //////////////////////////////////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         st  <= E_IDLE;
         cnt <= '0;
      end else begin
         case (st)
            E_IDLE: begin
               if (cmd_pop_o) begin
                  cur <= cmd_i;
                  cnt <= '0;
                  st  <= (cmd_i.instr == mem_port_pkg::CMD_WRITE) ? E_WR : E_RD;
               end
            end
            E_WR: begin
               if (wr_pop_o) begin
                  cnt <= cnt + 6'd1;
                  if (last)
                     st <= E_IDLE;
               end
            end
            E_RD: begin
               if (rd_push_o) begin
                  cnt <= cnt + 6'd1;
                  if (last)
                     st <= E_IDLE;
               end
            end
            default: st <= E_IDLE;
         endcase
      end
   end

   // byte merge, a set mask bit keeps the old byte
   always_ff @(posedge wb_clk) begin
      if (wr_pop_o) begin
         for (int b = 0; b < 4; b++) begin
            if (!wr_word_i.mask[b])
               mem[word_idx][8*b +: 8] <= wr_word_i.dat[8*b +: 8];
         end
      end
   end

endmodule

// File: logic/mem_top.sv
`timescale 1ns/1ps

module mem_top (
   input  logic                  wb_clk,
   input  logic                  mem_rst,
   input  mem_bus_pkg::wb_req_t  wb_req_i,
   output logic                  wb_ack_o,
   output logic                  wb_stall_o,
   output mem_bus_pkg::wb_data_t wb_dat_o
);

   //////////////////////////////////////////////////
   // port wires
   //////////////////////////////////////////////////

   mem_port_pkg::port_cmd_t cmd_in, cmd_out;     // command queue in and head
   logic                    cmd_push, cmd_pop, cmd_full, cmd_empty;
   mem_port_pkg::wr_word_t  wr_in, wr_out;       // write queue in and head
   logic                    wr_push, wr_pop, wr_full, wr_empty;
   mem_bus_pkg::wb_data_t   rd_in, rd_out;       // read queue in and head
   logic                    rd_push, rd_pop, rd_flush, rd_full, rd_empty;

   wb_burst_ctrl u_ctrl (
      .wb_clk, .mem_rst, .req_i(wb_req_i),
      .wr_full_i(wr_full), .cmd_full_i(cmd_full), .rd_empty_i(rd_empty), .rd_dat_i(rd_out),
      .wr_push_o(wr_push), .wr_word_o(wr_in), .cmd_push_o(cmd_push), .cmd_o(cmd_in),
      .rd_pop_o(rd_pop), .rd_flush_o(rd_flush),
      .ack_o(wb_ack_o), .stall_o(wb_stall_o), .dat_o(wb_dat_o)
   );

   port_fifo #(.WIDTH($bits(mem_port_pkg::port_cmd_t)), .DEPTH(mem_port_pkg::CMD_DEPTH)) u_cmd_fifo (
      .wb_clk, .mem_rst, .push_i(cmd_push), .push_dat_i(cmd_in), .pop_i(cmd_pop),
      .flush_i(1'b0), .pop_dat_o(cmd_out), .full_o(cmd_full), .empty_o(cmd_empty)
   );

   port_fifo #(.WIDTH($bits(mem_port_pkg::wr_word_t)), .DEPTH(mem_port_pkg::WR_DEPTH)) u_wr_fifo (
      .wb_clk, .mem_rst, .push_i(wr_push), .push_dat_i(wr_in), .pop_i(wr_pop),
      .flush_i(1'b0), .pop_dat_o(wr_out), .full_o(wr_full), .empty_o(wr_empty)
   );

   // read buffer, flushed by the controller on writes and misses
   port_fifo #(.WIDTH($bits(mem_bus_pkg::wb_data_t)), .DEPTH(mem_port_pkg::RD_DEPTH)) u_rd_fifo (
      .wb_clk, .mem_rst, .push_i(rd_push), .push_dat_i(rd_in), .pop_i(rd_pop),
      .flush_i(rd_flush), .pop_dat_o(rd_out), .full_o(rd_full), .empty_o(rd_empty)
   );

   burst_engine u_engine (
      .wb_clk, .mem_rst,
      .cmd_empty_i(cmd_empty), .cmd_i(cmd_out), .cmd_pop_o(cmd_pop),
      .wr_empty_i(wr_empty), .wr_word_i(wr_out), .wr_pop_o(wr_pop),
      .rd_full_i(rd_full), .rd_push_o(rd_push), .rd_dat_o(rd_in)
   );

endmodule

// File: sim/mem_tb.sv
`timescale 1ns/1ps

module mem_tb;

   // strobes over all tests: preload 4x48, single 2, block 40, seq 12, inval 3, long 140
   localparam int TOTAL_STB = 389;

   logic                   wb_clk;
   logic                   mem_rst;
   mem_bus_pkg::wb_req_t   req;
   logic                   wb_ack_o;
   logic                   wb_stall_o;
   mem_bus_pkg::wb_data_t  wb_dat_o;

   mem_bus_pkg::wb_data_t  ref_mem [1 << (mem_bus_pkg::ADDR_W - 2)];   // reference image
   mem_bus_pkg::wb_data_t  exp_q [$];   // expected read words in ack order
   logic [31:0]            lfsr;
   int                     stb_cnt;     // accepted strobes in this bus cycle
   int                     ack_cnt;     // acks seen in this bus cycle
   bit                     rd_cycle;
   bit                     stall_seen;
   string                  cur_test;

   mem_top UUT (
      .wb_clk, .mem_rst, .wb_req_i(req), .wb_ack_o, .wb_stall_o, .wb_dat_o
   );

   initial begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;   // 8 ns period
   end

   //////////////////////////////////////////////////
   // reference model and random source
   //////////////////////////////////////////////////

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};   // one new bit per step
      end
      return r;
   endfunction

   // bytes with sel set take the new data
   function automatic mem_bus_pkg::wb_data_t merge_ref(mem_bus_pkg::wb_data_t old_w,
                                                      mem_bus_pkg::wb_data_t new_w,
                                                      mem_bus_pkg::wb_sel_t  sel);
      mem_bus_pkg::wb_data_t r;
      r = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b])
            r[8*b +: 8] = new_w[8*b +: 8];
      end
      return r;
   endfunction

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_data(string name, mem_bus_pkg::wb_data_t exp_v,
                             mem_bus_pkg::wb_data_t act_v);
      if (act_v !== exp_v)
         abort_run($sformatf("error %s expected %h actual %h", name, exp_v, act_v));
   endtask

   task automatic check_count(string name, int exp_v, int act_v);
      if (act_v != exp_v)
         abort_run($sformatf("error %s expected %0d acks actual %0d", name, exp_v, act_v));
   endtask

   // outputs are registered, so the falling edge sees them settled
   always @(negedge wb_clk) begin
      if (wb_ack_o) begin
         ack_cnt++;
         if (rd_cycle) begin
            if (exp_q.size() == 0)
               abort_run($sformatf("%s got a read ack with no read outstanding", cur_test));
            else
               check_data(cur_test, exp_q.pop_front(), wb_dat_o);
         end
      end
   end

   initial begin
      repeat (TOTAL_STB * 40 + 1000) @(posedge wb_clk);
      abort_run($sformatf("watchdog expired in %s, the bus stopped answering", cur_test));
   end

   //////////////////////////////////////////////////
   // bus master
   //////////////////////////////////////////////////

   task automatic begin_cycle(string name, bit is_rd);
      @(negedge wb_clk);
      cur_test = name;
      rd_cycle = is_rd;
      stb_cnt  = 0;
      ack_cnt  = 0;
      req.cyc  = 1'b1;
      req.we   = !is_rd;
   endtask

   // hold the strobe while stalled, count it once accepted
   task automatic put_strobe(mem_bus_pkg::wb_addr_t a, mem_bus_pkg::wb_data_t d,
                             mem_bus_pkg::wb_sel_t s);
      req.stb  = 1'b1;
      req.addr = a;
      req.dat  = d;
      req.sel  = s;
      while (wb_stall_o) begin
         stall_seen = 1'b1;
         @(negedge wb_clk);
      end
      @(negedge wb_clk);
      stb_cnt++;
   endtask

   task automatic end_cycle(string name);
      req.stb = 1'b0;
      @(posedge wb_clk);
      while (ack_cnt < stb_cnt) @(posedge wb_clk);   // cyc stays up until the last ack
      @(negedge wb_clk);
      req.cyc = 1'b0;
      repeat (12) @(negedge wb_clk);   // bursts in flight land, stray acks show up
      @(posedge wb_clk);
      check_count(name, stb_cnt, ack_cnt);
   endtask

   task automatic write_block(string name, mem_bus_pkg::wb_addr_t base, int n, bit rnd_sel);
      mem_bus_pkg::wb_addr_t a;
      mem_bus_pkg::wb_data_t d;
      mem_bus_pkg::wb_sel_t  s;
      begin_cycle(name, 1'b0);
      for (int i = 0; i < n; i++) begin
         a = base + mem_bus_pkg::wb_addr_t'(i * mem_bus_pkg::WORD_BYTES);
         d = rand_bits(32);
         s = rnd_sel ? mem_bus_pkg::wb_sel_t'(rand_bits(4)) : 4'hf;
         ref_mem[a[mem_bus_pkg::ADDR_W-1:2]] = merge_ref(ref_mem[a[mem_bus_pkg::ADDR_W-1:2]], d, s);
         put_strobe(a, d, s);
      end
      end_cycle(name);
   endtask

   task automatic read_block(string name, mem_bus_pkg::wb_addr_t base, int n);
      mem_bus_pkg::wb_addr_t a;
      begin_cycle(name, 1'b1);
      for (int i = 0; i < n; i++) begin
         a = base + mem_bus_pkg::wb_addr_t'(i * mem_bus_pkg::WORD_BYTES);
         exp_q.push_back(ref_mem[a[mem_bus_pkg::ADDR_W-1:2]]);
         put_strobe(a, '0, 4'hf);
      end
      end_cycle(name);
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      req        = '0;
      mem_rst    = 1'b1;
      lfsr       = 32'h4623;
      stb_cnt    = 0;
      ack_cnt    = 0;
      rd_cycle   = 1'b0;
      stall_seen = 1'b0;
      cur_test   = "reset";
      repeat (3) @(posedge wb_clk);
      @(negedge wb_clk);
      mem_rst = 1'b0;
      @(negedge wb_clk);
      if (wb_ack_o !== 1'b0 || wb_stall_o !== 1'b0)
         abort_run("ack or stall is not low after reset");
      // full sel fill of words 0 to 191 so partial writes merge into known data
      for (int p = 0; p < 4; p++)
         write_block("preload", mem_bus_pkg::wb_addr_t'(p * 192), 48, 1'b0);
      write_block("single_write", 12'h800, 1, 1'b0);
      read_block("single_read", 12'h800, 1);
      write_block("block_write", 12'h100, 20, 1'b1);
      read_block("block_read", 12'h100, 20);   // bursts at 0x100, 0x120, 0x140
      // first read misses with old words still buffered, then hits up to a second miss
      for (int r = 0; r < 12; r++)
         read_block("seq_read", 12'h180 + mem_bus_pkg::wb_addr_t'(r * 4), 1);
      read_block("inval_read_a", 12'h200, 1);
      write_block("inval_write", 12'h204, 1, 1'b0);
      read_block("inval_read_b", 12'h204, 1);   // must not come from the old buffer
      stall_seen = 1'b0;
      write_block("long_write", 12'h000, 70, 1'b1);
      if (!stall_seen)
         abort_run("stall never rose during the long write block");
      read_block("long_read", 12'h000, 70);
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: flist.f
logic/mem_bus_pkg.sv
logic/mem_port_pkg.sv
logic/port_fifo.sv
logic/wb_burst_ctrl.sv
logic/burst_engine.sv
logic/mem_top.sv
sim/mem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the wishbone memory port testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module mem_tb -f flist.f -o Vmem_tb

# tee keeps the log even when the simulation stops early
./obj_dir/Vmem_tb | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation passed"
exit 0
